/* Makefile */
BIN := obj_dir/Vfetch_tb
SRCS := $(wildcard logic/*.sv logic/*.svh test/*.sv)

.PHONY: all run check-log clean

all: check-log

$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module fetch_tb -Mdir obj_dir

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 | tee sim.log

check-log: run
	grep -qx "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* logic/cache_pkg.sv */
`include "fetch_settings.svh"

package cache_pkg;

	localparam int ENTRIES  = 1 << `FETCH_INDEX_BITS;
	localparam int TAG_BITS = 30 - `FETCH_INDEX_BITS; // Above index and byte offset

	typedef logic [`FETCH_INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0]          tag_t;

	typedef struct packed {
		logic        valid;
		tag_t        tag;
		logic [31:0] word;
	} entry_t;

	function automatic index_t index_of(logic [31:0] addr);
		return addr[`FETCH_INDEX_BITS+1:2];
	endfunction

	function automatic tag_t tag_of(logic [31:0] addr);
		return addr[31:`FETCH_INDEX_BITS+2];
	endfunction

endpackage

/* logic/fetch_pkg.sv */
package fetch_pkg;

	// Two 32-bit instruction lanes in one memory beat
	typedef struct packed {
		logic [31:0] hi;
		logic [31:0] lo;
	} lanes_t;

	// A beat is read either as the raw bus word or per lane
	typedef union packed {
		logic [63:0] raw;
		lanes_t      lanes;
	} mem_beat_t;

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		MISS = 2'b10 // Only on the cache lookup channel
	} resp_t;

	typedef enum logic [1:0] {CTRL, HITS, MISSES, BUSY} reg_addr_t;

endpackage

/* logic/fetch_regs.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_regs (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         cfg_write,
	input  fetch_pkg::reg_addr_t         cfg_addr,
	input  logic                         cfg_wdata,
	input  logic                         hit_event,
	input  logic                         miss_event,
	input  logic                         busy,
	output logic [`FETCH_COUNT_BITS-1:0] cfg_rdata,
	output logic                         cache_enable
);
	typedef logic [`FETCH_COUNT_BITS-1:0] count_t;

	count_t hits, misses, busy_cycles;

	// Count up by one, stop at all ones
	function automatic count_t bump(count_t value, logic event_in);
		return (event_in && value != '1) ? value + 1'b1 : value;
	endfunction

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			cache_enable <= 1'b1;
			hits         <= '0;
			misses       <= '0;
			busy_cycles  <= '0;
		end else begin
			hits        <= bump(hits, hit_event);
			misses      <= bump(misses, miss_event);
			busy_cycles <= bump(busy_cycles, busy);
			if (cfg_write) begin
				case (cfg_addr)
					fetch_pkg::CTRL:   cache_enable <= cfg_wdata;
					fetch_pkg::HITS:   hits <= '0;
					fetch_pkg::MISSES: misses <= '0;
					fetch_pkg::BUSY:   busy_cycles <= '0;
					default:           cache_enable <= cache_enable;
				endcase
			end
		end
	end

	always_comb begin
		case (cfg_addr)
			fetch_pkg::CTRL:   cfg_rdata = {{(`FETCH_COUNT_BITS-1){1'b0}}, cache_enable};
			fetch_pkg::HITS:   cfg_rdata = hits;
			fetch_pkg::MISSES: cfg_rdata = misses;
			fetch_pkg::BUSY:   cfg_rdata = busy_cycles;
			default:           cfg_rdata = '0;
		endcase
	end

endmodule

/* logic/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Uncached on-chip SRAM window, base inclusive and limit exclusive
`define FETCH_SRAM_BASE  32'h0f00_0000
`define FETCH_SRAM_LIMIT 32'h0f00_2000

// Cache index width, 16 single-word entries
`define FETCH_INDEX_BITS 4

// First program counter after reset
`define FETCH_RESET_PC   32'h8000_0000

// Performance counter width
`define FETCH_COUNT_BITS 32

`endif

/* logic/fetch_top.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_top (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         wb_valid,
	input  logic [31:0]                  pc,
	output logic [31:0]                  inst,
	output logic                         idu_valid,

	output logic [31:0]                  mem_araddr,
	output logic                         mem_arvalid,
	input  logic                         mem_arready,
	input  logic [63:0]                  mem_rdata,
	input  fetch_pkg::resp_t             mem_rresp,
	input  logic                         mem_rvalid,
	output logic                         mem_rready,

	input  logic                         cfg_write,
	input  fetch_pkg::reg_addr_t         cfg_addr,
	input  logic                         cfg_wdata,
	output logic [`FETCH_COUNT_BITS-1:0] cfg_rdata
);
	logic cache_enable, hit_event, miss_event, busy;

	logic [31:0]      cache_araddr, cache_rdata, cache_awaddr, cache_wdata;
	logic             cache_arvalid, cache_arready, cache_rvalid, cache_rready;
	fetch_pkg::resp_t cache_rresp;
	logic             cache_awvalid, cache_awready, cache_wvalid, cache_wready;
	logic             cache_bvalid, cache_bready;

	assign mem_rready = 1'b1; // Unit always takes read data

	fetch_unit fetch_unit_inst (
		.clock, .rst_n, .wb_valid, .pc, .cache_enable,
		.inst, .idu_valid, .hit_event, .miss_event, .busy,
		.mem_araddr, .mem_arvalid, .mem_arready,
		.mem_rdata, .mem_rresp, .mem_rvalid,
		.cache_araddr, .cache_arvalid, .cache_arready,
		.cache_rdata, .cache_rresp, .cache_rvalid, .cache_rready,
		.cache_awaddr, .cache_awvalid, .cache_awready,
		.cache_wdata, .cache_wvalid, .cache_wready,
		.cache_bvalid, .cache_bready
	);

	icache icache_inst (
		.clock, .rst_n,
		.cache_araddr, .cache_arvalid, .cache_arready,
		.cache_rdata, .cache_rresp, .cache_rvalid, .cache_rready,
		.cache_awaddr, .cache_awvalid, .cache_awready,
		.cache_wdata, .cache_wvalid, .cache_wready,
		.cache_bvalid, .cache_bready
	);

	fetch_regs fetch_regs_inst (
		.clock, .rst_n,
		.cfg_write, .cfg_addr, .cfg_wdata,
		.hit_event, .miss_event, .busy,
		.cfg_rdata, .cache_enable
	);

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_unit (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             wb_valid,
	input  logic [31:0]      pc,
	input  logic             cache_enable,
	output logic [31:0]      inst,
	output logic             idu_valid,
	output logic             hit_event,
	output logic             miss_event,
	output logic             busy,

	output logic [31:0]      mem_araddr,
	output logic             mem_arvalid,
	input  logic             mem_arready,
	input  logic [63:0]      mem_rdata,
	input  fetch_pkg::resp_t mem_rresp,
	input  logic             mem_rvalid,

	output logic [31:0]      cache_araddr,
	output logic             cache_arvalid,
	input  logic             cache_arready,
	input  logic [31:0]      cache_rdata,
	input  fetch_pkg::resp_t cache_rresp,
	input  logic             cache_rvalid,
	output logic             cache_rready,
	output logic [31:0]      cache_awaddr,
	output logic             cache_awvalid,
	input  logic             cache_awready,
	output logic [31:0]      cache_wdata,
	output logic             cache_wvalid,
	input  logic             cache_wready,
	input  logic             cache_bvalid,
	output logic             cache_bready
);
	fetch_pkg::mem_beat_t beat;
	logic [31:0] mem_word;
	logic mem_rready;
	logic start, pending, cached;
	logic in_sram, cacheable;
	logic cache_hit, cache_miss, mem_done, mem_ok, fill_done, over;

	assign mem_rready   = 1'b1;
	assign cache_rready = 1'b1;
	assign cache_bready = 1'b1;

	assign mem_araddr   = {pc[31:3], 3'b000}; // Beat aligned
	assign cache_araddr = pc;
	assign cache_awaddr = pc;
	assign cache_wdata  = inst; // Already holds the fetched word when wvalid rises

	assign in_sram   = (pc >= `FETCH_SRAM_BASE) && (pc < `FETCH_SRAM_LIMIT);
	assign cacheable = ~in_sram & cache_enable;

	assign beat.raw = mem_rdata;
	assign mem_word = pc[2] ? beat.lanes.hi : beat.lanes.lo;

	assign cache_hit  = cache_rvalid & cache_rready & (cache_rresp == fetch_pkg::OKAY);
	assign cache_miss = cache_rvalid & cache_rready & (cache_rresp == fetch_pkg::MISS);
	assign mem_done   = mem_rvalid & mem_rready;
	assign mem_ok     = mem_done & (mem_rresp == fetch_pkg::OKAY);
	assign fill_done  = cache_bvalid & cache_bready;

	// Fetch ends on a hit, on the fill answer, or on memory data that is not filled
	assign over = cache_hit | fill_done | mem_done & ~(cached & mem_ok);

	assign hit_event  = cache_hit;
	assign miss_event = cache_miss;
	assign busy       = start | pending;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			start         <= 1'b0;
			pending       <= 1'b0;
			cached        <= 1'b0;
			cache_arvalid <= 1'b0;
			mem_arvalid   <= 1'b0;
			cache_awvalid <= 1'b0;
			cache_wvalid  <= 1'b0;
			idu_valid     <= 1'b0;
		end else begin
			start <= ~start & wb_valid;
			if (start)
				cached <= cacheable; // Route fixed for the whole fetch
			if (start)
				pending <= 1'b1;
			else if (idu_valid)
				pending <= 1'b0;

			// Each valid holds until its ready is seen
			cache_arvalid <= cache_arvalid ? ~cache_arready : start & cacheable;
			mem_arvalid   <= mem_arvalid ? ~mem_arready : start & ~cacheable | cache_miss;
			cache_awvalid <= cache_awvalid ? ~cache_awready : mem_ok & cached;
			cache_wvalid  <= cache_wvalid ? ~cache_wready : mem_ok & cached;

			idu_valid <= ~idu_valid & over;
		end
	end

	always_ff @(posedge clock) begin
		if (cache_hit)
			inst <= cache_rdata;
		else if (mem_done)
			inst <= mem_word;
	end

endmodule

/* logic/icache.sv */
`timescale 1ns/1ns

module icache (
	input  logic             clock,
	input  logic             rst_n,
	input  logic [31:0]      cache_araddr,
	input  logic             cache_arvalid,
	output logic             cache_arready,
	output logic [31:0]      cache_rdata,
	output fetch_pkg::resp_t cache_rresp,
	output logic             cache_rvalid,
	input  logic             cache_rready,
	input  logic [31:0]      cache_awaddr,
	input  logic             cache_awvalid,
	output logic             cache_awready,
	input  logic [31:0]      cache_wdata,
	input  logic             cache_wvalid,
	output logic             cache_wready,
	output logic             cache_bvalid,
	input  logic             cache_bready
);
	cache_pkg::entry_t entries [cache_pkg::ENTRIES];
	cache_pkg::entry_t look;
	logic lookup, hit;
	logic aw_got, w_got;
	logic aw_take, w_take, fill;
	logic [31:0] fill_addr, fill_word;
	logic [31:0] wr_addr, wr_word;

	assign cache_arready = 1'b1;
	assign lookup = cache_arvalid & cache_arready;
	assign look   = entries[cache_pkg::index_of(cache_araddr)];
	assign hit    = look.valid && (look.tag == cache_pkg::tag_of(cache_araddr));

	// aw and w may arrive in either order, no new fill while the answer waits
	assign cache_awready = ~aw_got & ~cache_bvalid;
	assign cache_wready  = ~w_got & ~cache_bvalid;
	assign aw_take = cache_awvalid & cache_awready;
	assign w_take  = cache_wvalid & cache_wready;
	assign fill    = (aw_got | aw_take) & (w_got | w_take);
	assign wr_addr = aw_got ? fill_addr : cache_awaddr;
	assign wr_word = w_got ? fill_word : cache_wdata;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < cache_pkg::ENTRIES; i++) begin
				entries[i] <= '0;
			end
			cache_rvalid <= 1'b0;
			cache_rresp  <= fetch_pkg::OKAY;
			aw_got       <= 1'b0;
			w_got        <= 1'b0;
			cache_bvalid <= 1'b0;
		end else begin
			cache_rvalid <= cache_rvalid & ~cache_rready | lookup; // Answer one cycle later
			if (lookup) begin
				if (hit)
					cache_rresp <= fetch_pkg::OKAY;
				else
					cache_rresp <= fetch_pkg::MISS;
			end

			if (fill) begin
				entries[cache_pkg::index_of(wr_addr)] <= '{
					valid: 1'b1,
					tag:   cache_pkg::tag_of(wr_addr),
					word:  wr_word
				};
				aw_got <= 1'b0;
				w_got  <= 1'b0;
			end else begin
				aw_got <= aw_got | aw_take;
				w_got  <= w_got | w_take;
			end
			cache_bvalid <= cache_bvalid & ~cache_bready | fill;
		end
	end

	always_ff @(posedge clock) begin
		if (lookup)
			cache_rdata <= look.word;
		if (aw_take)
			fill_addr <= cache_awaddr; // Kept until w arrives
		if (w_take)
			fill_word <= cache_wdata;
	end

endmodule

/* sim.f */
+incdir+logic
logic/fetch_pkg.sv
logic/cache_pkg.sv
logic/fetch_unit.sv
logic/icache.sv
logic/fetch_regs.sv
logic/fetch_top.sv
test/tb_clock.sv
test/fetch_checker.sv
test/fetch_monitor.sv
test/fetch_tb.sv

/* test/fetch_checker.sv */
`timescale 1ns/1ns

module fetch_checker (
	input logic clock,
	input logic rst_n,
	input logic mem_arvalid,
	input logic mem_arready,
	input logic cache_arvalid,
	input logic cache_arready,
	input logic cache_rvalid,
	input logic cache_awvalid,
	input logic cache_awready,
	input logic cache_wvalid,
	input logic cache_wready,
	input logic idu_valid
);
	int failures = 0;

	mem_ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
		mem_arvalid && !mem_arready |=> mem_arvalid) else begin
		$error("mem_arvalid dropped before mem_arready");
		failures++;
	end

	// The cache answers one cycle after it takes a lookup
	cache_answer: assert property (@(posedge clock) disable iff (!rst_n)
		cache_arvalid && cache_arready |=> cache_rvalid) else begin
		$error("cache_rvalid missing one cycle after a lookup");
		failures++;
	end

	cache_aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
		cache_awvalid && !cache_awready |=> cache_awvalid) else begin
		$error("cache_awvalid dropped before cache_awready");
		failures++;
	end

	cache_w_hold: assert property (@(posedge clock) disable iff (!rst_n)
		cache_wvalid && !cache_wready |=> cache_wvalid) else begin
		$error("cache_wvalid dropped before cache_wready");
		failures++;
	end

	// One fetch ends in a single cycle
	idu_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		idu_valid |=> !idu_valid) else begin
		$error("idu_valid high for two cycles in a row");
		failures++;
	end

endmodule

/* test/fetch_monitor.sv */
`timescale 1ns/1ns

module fetch_monitor (
	input logic        clock,
	input logic        wb_valid,
	input logic        idu_valid,
	input logic [31:0] inst
);
	localparam int HIT_CYCLES = 4; // wb_valid to idu_valid on a hit

	int passed = 0;
	int failed = 0;
	int cycles = 0;
	int latency = 0;
	logic [31:0] fetched = '0;

	// Rising edges from wb_valid to idu_valid
	always @(posedge clock) begin
		if (wb_valid)
			cycles <= 0;
		else
			cycles <= cycles + 1;
		if (idu_valid) begin
			latency <= cycles + 1;
			fetched <= inst;
		end
	end

	task automatic compare_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual, inout int wrong);
		if (actual !== expected) begin
			$display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
			wrong++;
		end
	endtask

	// Busy counts every cycle of the fetch, so it equals the latency
	task automatic check_fetch(input string name, input logic [31:0] exp_inst,
		input int exp_hits, input int exp_misses, input int exp_busy,
		input int got_hits, input int got_misses, input int got_busy);
		int wrong;
		wrong = 0;
		compare_value(name, "inst", exp_inst, fetched, wrong);
		compare_value(name, "hits", exp_hits, got_hits, wrong);
		compare_value(name, "misses", exp_misses, got_misses, wrong);
		compare_value(name, "busy", (exp_busy != 0) ? exp_busy : latency, got_busy, wrong);
		if (exp_hits != 0)
			compare_value(name, "latency", HIT_CYCLES, latency, wrong);
		if (wrong == 0) begin
			passed++;
			$display("Pass %s (%0d cycles)", name, latency);
		end else begin
			failed++;
		end
	endtask

endmodule

/* test/fetch_tb.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_tb;
	localparam int NUM_TESTS = 10;
	localparam int RESET_CYCLES = 16;

	typedef struct packed {
		logic        cfg_write; // Write CTRL before the fetch
		logic        cfg_value;
		logic [31:0] pc;
		logic [31:0] inst;
		logic [3:0]  hits;      // Counter changes
		logic [3:0]  misses;
		logic [7:0]  busy;      // 0 where the memory delay makes it vary
	} test_t;

	logic clock, rst_n, wb_valid, idu_valid, cfg_write, cfg_wdata;
	logic mem_arvalid, mem_arready, mem_rvalid, mem_rready;
	logic [31:0] pc, inst, mem_araddr;
	logic [63:0] mem_rdata;
	fetch_pkg::resp_t mem_rresp;
	fetch_pkg::reg_addr_t cfg_addr;
	logic [`FETCH_COUNT_BITS-1:0] cfg_rdata;

	string names [NUM_TESTS] = '{"miss_first", "hit_repeat", "sram_lo", "sram_hi",
		"evict_other", "refetch_evicted", "off_cached", "off_other", "on_miss", "on_hit"};

	// cfg write, cfg value, pc, inst, hits, misses, busy
	test_t tests [NUM_TESTS] = '{
		'{1'b0, 1'b0, 32'h8000_0004, 32'hda5a_0004, 4'd0, 4'd1, 8'd0},
		'{1'b0, 1'b0, 32'h8000_0004, 32'hda5a_0004, 4'd1, 4'd0, 8'd4},
		'{1'b0, 1'b0, 32'h0f00_0100, 32'h555a_0100, 4'd0, 4'd0, 8'd0},
		'{1'b0, 1'b0, 32'h0f00_0104, 32'h555a_0104, 4'd0, 4'd0, 8'd0},
		'{1'b0, 1'b0, 32'h8000_0044, 32'hda5a_0044, 4'd0, 4'd1, 8'd0}, // Same index
		'{1'b0, 1'b0, 32'h8000_0004, 32'hda5a_0004, 4'd0, 4'd1, 8'd0},
		'{1'b1, 1'b0, 32'h8000_0004, 32'hda5a_0004, 4'd0, 4'd0, 8'd0},
		'{1'b0, 1'b0, 32'h8000_0044, 32'hda5a_0044, 4'd0, 4'd0, 8'd0},
		'{1'b1, 1'b1, 32'h8000_0044, 32'hda5a_0044, 4'd0, 4'd1, 8'd0},
		'{1'b0, 1'b0, 32'h8000_0044, 32'hda5a_0044, 4'd1, 4'd0, 8'd4}
	};

	tb_clock clock_gen (.clock);
	fetch_top fetch_top_inst (.*);
	fetch_monitor fetch_monitor_inst (.clock, .wb_valid, .idu_valid, .inst);

	bind fetch_unit fetch_checker fetch_checker_inst (
		.clock, .rst_n, .mem_arvalid, .mem_arready, .cache_arvalid, .cache_arready,
		.cache_rvalid, .cache_awvalid, .cache_awready, .cache_wvalid, .cache_wready,
		.idu_valid
	);

	// Memory beats hold each lane's byte address XOR 5a5a0000
	initial begin : memory_responder
		logic [31:0] addr;
		fetch_pkg::mem_beat_t beat;
		void'($urandom(32'hbb1f));
		mem_arready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		mem_rresp = fetch_pkg::OKAY;
		forever begin
			@(posedge clock);
			if (mem_arvalid) begin
				addr = mem_araddr;
				repeat ($urandom % 6) @(posedge clock);
				#1 mem_arready = 1'b1;
				@(posedge clock);
				#1 mem_arready = 1'b0;
				beat.lanes.lo = addr ^ 32'h5a5a_0000;
				beat.lanes.hi = (addr + 32'd4) ^ 32'h5a5a_0000;
				mem_rdata = beat.raw;
				mem_rvalid = 1'b1;
				do @(posedge clock); while (!mem_rready);
				#1 mem_rvalid = 1'b0;
			end
		end
	end

	task automatic read_reg(input fetch_pkg::reg_addr_t addr,
		output logic [`FETCH_COUNT_BITS-1:0] value);
		@(posedge clock);
		#1 cfg_addr = addr;
		@(negedge clock);
		value = cfg_rdata;
	endtask

	task automatic write_ctrl(input logic value);
		@(posedge clock);
		#1;
		cfg_write = 1'b1;
		cfg_addr = fetch_pkg::CTRL;
		cfg_wdata = value;
		@(posedge clock);
		#1 cfg_write = 1'b0;
	endtask

	task automatic run_test(input int i);
		logic [`FETCH_COUNT_BITS-1:0] h0, m0, b0, h1, m1, b1;
		read_reg(fetch_pkg::HITS, h0);
		read_reg(fetch_pkg::MISSES, m0);
		read_reg(fetch_pkg::BUSY, b0);
		if (tests[i].cfg_write)
			write_ctrl(tests[i].cfg_value);
		@(posedge clock);
		#1;
		pc = tests[i].pc;
		wb_valid = 1'b1;
		@(posedge clock);
		#1 wb_valid = 1'b0;
		do @(posedge clock); while (!idu_valid);
		read_reg(fetch_pkg::HITS, h1);
		read_reg(fetch_pkg::MISSES, m1);
		read_reg(fetch_pkg::BUSY, b1);
		fetch_monitor_inst.check_fetch(names[i], tests[i].inst, tests[i].hits, tests[i].misses,
			tests[i].busy, int'(h1 - h0), int'(m1 - m0), int'(b1 - b0));
	endtask

	initial begin : watchdog
		repeat (RESET_CYCLES + NUM_TESTS * 40) @(posedge clock);
		$display("Watchdog expired before all fetches completed");
		$display("TEST FAILED");
		$finish;
	end

	initial begin : stimulus
		int asserts;
		rst_n = 1'b0;
		wb_valid = 1'b0;
		pc = '0;
		cfg_write = 1'b0;
		cfg_addr = fetch_pkg::CTRL;
		cfg_wdata = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 rst_n = 1'b1;
		for (int i = 0; i < NUM_TESTS; i++)
			run_test(i);
		asserts = fetch_top_inst.fetch_unit_inst.fetch_checker_inst.failures;
		$display("Summary: %0d passed, %0d failed, %0d assertion failures",
			fetch_monitor_inst.passed, fetch_monitor_inst.failed, asserts);
		if (fetch_monitor_inst.failed == 0 && asserts == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(parameter int PERIOD = 10) (
	output logic clock
);
	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

endmodule
